/* logic/core_pkg.sv */
// core package: data widths, instruction encodings, select codes and state types
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  mem_addr_t;
  typedef logic [15:0] count_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [1:0]  imm_sel_t;
  typedef logic [1:0]  wb_sel_t;
  typedef logic        src_sel_t;
  typedef logic [2:0]  alu_op_t;
  typedef logic [1:0]  host_cmd_t;

  // primary opcodes, instruction bits 30..25
  localparam opcode_t TYPE_BASIC = 6'b100000;
  localparam opcode_t ADDI       = 6'b101000;
  localparam opcode_t ORI        = 6'b101100;
  localparam opcode_t XORI       = 6'b101011;
  localparam opcode_t LWI        = 6'b000010;
  localparam opcode_t SWI        = 6'b001010;
  localparam opcode_t MOVI       = 6'b100010;
  localparam opcode_t BEQ        = 6'b100110;
  localparam opcode_t J          = 6'b100100;
  localparam opcode_t TYPE_LS    = 6'b011100;

  // basic sub-opcodes in bits 4..0
  localparam logic [4:0] ADD   = 5'b00000;
  localparam logic [4:0] SUB   = 5'b00001;
  localparam logic [4:0] AND   = 5'b00010;
  localparam logic [4:0] OR    = 5'b00100;
  localparam logic [4:0] XOR   = 5'b00011;
  localparam logic [4:0] SRLI  = 5'b01001;
  localparam logic [4:0] SLLI  = 5'b01000;
  localparam logic [4:0] ROTRI = 5'b01011;

  // load/store sub-opcodes in bits 7..0
  localparam logic [7:0] LW = 8'b00000010;
  localparam logic [7:0] SW = 8'b00001010;

  localparam imm_sel_t IMM5_ZE  = 2'd0;
  localparam imm_sel_t IMM15_SE = 2'd1;
  localparam imm_sel_t IMM15_ZE = 2'd2;
  localparam imm_sel_t IMM20_SE = 2'd3;

  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_DMEM = 2'd1;

  localparam src_sel_t SRC_REG = 1'b0;
  localparam src_sel_t SRC_IMM = 1'b1;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  localparam alu_op_t ALU_SRL = 3'd5;
  localparam alu_op_t ALU_SLL = 3'd6;
  localparam alu_op_t ALU_ROR = 3'd7;

  typedef enum logic [3:0] {
    ST_STOP        = 4'd0,
    ST_FETCH       = 4'd1,
    ST_EXECUTE     = 4'd2,
    ST_WRITE       = 4'd3,
    ST_LOAD_READ   = 4'd4,
    ST_LOAD_WAIT   = 4'd5,
    ST_STORE_READ  = 4'd6,
    ST_STORE_WRITE = 4'd7,
    ST_UPDATE_PC   = 4'd8
  } ctrl_state_t;

  localparam host_cmd_t CMD_WRITE_IMEM = 2'd0;
  localparam host_cmd_t CMD_WRITE_DMEM = 2'd1;
  localparam host_cmd_t CMD_READ_DMEM  = 2'd2;
  localparam host_cmd_t CMD_START      = 2'd3;

endpackage

/* logic/alu.sv */
// alu: add, subtract, logic ops, shifts and rotate right, with an equality flag
`timescale 1ns/1ps

module alu import core_pkg::*; (
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output logic    equal
);

  logic [4:0]  shamt;
  logic [63:0] rotated;

  assign shamt = b[4:0];
  // doubled word shifted right gives the rotate in the low half
  assign rotated = {a, a} >> shamt;

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SRL: result = a >> shamt;
      ALU_SLL: result = a << shamt;
      ALU_ROR: result = rotated[31:0];
    endcase
  end

  assign equal = (a == b);

endmodule

/* logic/register_file.sv */
// register file: 32 by 32-bit, two combinational read ports, one write port, r0 reads zero
`timescale 1ns/1ps

module register_file import core_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t read_a,
  input  reg_addr_t read_b,
  input  reg_addr_t write_addr,
  input  word_t     write_data,
  input  logic      write_enable,
  output word_t     data_a,
  output word_t     data_b
);

  word_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (write_addr != 5'd0)) begin
      regs[write_addr] <= write_data;
    end
  end

  assign data_a = (read_a == 5'd0) ? '0 : regs[read_a];
  assign data_b = (read_b == 5'd0) ? '0 : regs[read_b];

endmodule

/* logic/instr_memory.sv */
// instruction memory: 256 words, written by the loader, registered read by the core
`timescale 1ns/1ps

module instr_memory import core_pkg::*; (
  input  logic      clock,
  input  logic      we,
  input  mem_addr_t write_addr,
  input  word_t     write_data,
  input  mem_addr_t read_addr,
  output word_t     read_data
);

  word_t mem [256];

  always_ff @(posedge clock) begin
    if (we) begin
      mem[write_addr] <= write_data;
    end
    read_data <= mem[read_addr];
  end

endmodule

/* logic/data_memory.sv */
// data memory: 256 words, single port with registered read
`timescale 1ns/1ps

module data_memory import core_pkg::*; (
  input  logic      clock,
  input  logic      we,
  input  mem_addr_t addr,
  input  word_t     wdata,
  output word_t     rdata
);

  word_t mem [256];

  // read returns the old word on a write cycle
  always_ff @(posedge clock) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

/* logic/program_loader.sv */
// program loader: four-phase host port for memory access, program length and run start
`timescale 1ns/1ps

module program_loader import core_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      host_req,
  input  host_cmd_t host_cmd,
  input  mem_addr_t host_addr,
  input  word_t     host_wdata,
  input  logic      done,
  input  word_t     dmem_rdata,
  output logic      host_ack,
  output word_t     host_rdata,
  output logic      start,
  output count_t    program_length,
  output logic      running,
  output logic      imem_we,
  output mem_addr_t imem_addr,
  output word_t     imem_wdata,
  output logic      host_dmem_we,
  output mem_addr_t host_dmem_addr,
  output word_t     host_dmem_wdata
);

  typedef enum logic [2:0] {
    LD_IDLE,
    LD_ACT,
    LD_WAIT_READ,
    LD_ACK,
    LD_WAIT_RELEASE
  } loader_state_t;

  loader_state_t state;

  always_ff @(posedge clock) begin
    if (reset) begin
      state          <= LD_IDLE;
      running        <= 1'b0;
      program_length <= '0;
    end else begin
      if (start) begin
        running        <= 1'b1;
        program_length <= host_wdata[15:0];
      end else if (done) begin
        running <= 1'b0;
      end
      case (state)
        LD_IDLE: begin
          // requests wait here until the run is over
          if (host_req && !running) begin
            state <= (host_cmd == CMD_READ_DMEM) ? LD_WAIT_READ : LD_ACT;
          end
        end
        LD_ACT, LD_WAIT_READ: state <= LD_ACK;
        LD_ACK:               state <= host_req ? LD_WAIT_RELEASE : LD_IDLE;
        LD_WAIT_RELEASE: begin
          if (!host_req) begin
            state <= LD_IDLE;
          end
        end
        default: state <= LD_IDLE;
      endcase
    end
  end

  // memory already addressed by host_addr while idle
  always_ff @(posedge clock) begin
    if (state == LD_WAIT_READ) begin
      host_rdata <= dmem_rdata;
    end
  end

  assign host_ack     = (state == LD_ACK) || (state == LD_WAIT_RELEASE);
  assign start        = (state == LD_ACT) && (host_cmd == CMD_START);
  assign imem_we      = (state == LD_ACT) && (host_cmd == CMD_WRITE_IMEM);
  assign host_dmem_we = (state == LD_ACT) && (host_cmd == CMD_WRITE_DMEM);

  assign imem_addr       = host_addr;
  assign imem_wdata      = host_wdata;
  assign host_dmem_addr  = host_addr;
  assign host_dmem_wdata = host_wdata;

endmodule

/* logic/ir_controller.sv */
// instruction controller: instruction register, nine-state sequencer, decode and run status
`timescale 1ns/1ps

module ir_controller import core_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      start,
  input  count_t    program_length,
  input  mem_addr_t pc,
  input  word_t     imem_rdata,
  input  logic      alu_equal,
  output logic      pc_set,
  output logic      pc_advance,
  output logic      reg_read,
  output logic      reg_write,
  output logic      alu_execute,
  output logic      dmem_read,
  output logic      dmem_write,
  output imm_sel_t  imm_sel,
  output src_sel_t  src_sel_a,
  output src_sel_t  src_sel_b,
  output wb_sel_t   wb_sel,
  output alu_op_t   alu_op,
  output reg_addr_t rt,
  output reg_addr_t ra,
  output reg_addr_t rb,
  output word_t     imm_field,
  output count_t    ins_count,
  output logic      done
);

  word_t       ir;
  ctrl_state_t state;
  logic        active;
  opcode_t     opcode;
  logic [4:0]  sub5;
  logic [7:0]  sub8;
  logic        is_nop;
  logic        is_load;
  logic        is_store;
  logic        is_beq;
  logic        is_j;
  logic        take_branch;

  assign opcode    = ir[30:25];
  assign sub5      = ir[4:0];
  assign sub8      = ir[7:0];
  assign rt        = ir[24:20];
  assign ra        = ir[19:15];
  assign rb        = ir[14:10];
  assign imm_field = ir;

  // nop is srli with a zero shift amount
  assign is_nop   = (opcode == TYPE_BASIC) && (sub5 == SRLI) && (rb == 5'd0);
  assign is_load  = (opcode == LWI) || ((opcode == TYPE_LS) && (sub8 == LW));
  assign is_store = (opcode == SWI) || ((opcode == TYPE_LS) && (sub8 == SW));
  assign is_beq   = (opcode == BEQ);
  assign is_j     = (opcode == J);
  assign take_branch = is_j || (is_beq && alu_equal);

  always_ff @(posedge clock) begin
    if (reset) begin
      ir <= '0;
    end else if (state == ST_FETCH) begin
      ir <= imem_rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= ST_STOP;
      active    <= 1'b0;
      done      <= 1'b0;
      ins_count <= '0;
    end else if (start) begin
      state     <= ST_STOP;
      active    <= 1'b1;
      done      <= 1'b0;
      ins_count <= '0;
    end else begin
      case (state)
        ST_STOP: begin
          // idle when not active; the run ends once pc hits the length
          if (active) begin
            if ({8'd0, pc} == program_length) begin
              active <= 1'b0;
              done   <= 1'b1;
            end else begin
              state <= ST_FETCH;
            end
          end
        end
        ST_FETCH:       state <= ST_EXECUTE;
        ST_EXECUTE:     state <= ST_LOAD_READ;
        ST_LOAD_READ:   state <= ST_LOAD_WAIT;
        ST_LOAD_WAIT:   state <= ST_WRITE;
        ST_WRITE:       state <= ST_STORE_READ;
        ST_STORE_READ:  state <= ST_STORE_WRITE;
        ST_STORE_WRITE: state <= ST_UPDATE_PC;
        ST_UPDATE_PC: begin
          state <= ST_STOP;
          if (!is_nop) begin
            ins_count <= ins_count + 1'b1;
          end
        end
        default: state <= ST_STOP;
      endcase
    end
  end

  always_comb begin
    pc_set      = 1'b0;
    pc_advance  = 1'b0;
    reg_read    = 1'b0;
    reg_write   = 1'b0;
    alu_execute = 1'b0;
    dmem_read   = 1'b0;
    dmem_write  = 1'b0;
    case (state)
      ST_EXECUTE: begin
        alu_execute = 1'b1;
        // beq compares rt, so read it during execute
        reg_read    = is_beq;
      end
      ST_LOAD_READ, ST_LOAD_WAIT: dmem_read = is_load;
      ST_WRITE:       reg_write  = !(is_nop || is_store || is_beq || is_j);
      ST_STORE_READ:  reg_read   = is_store;
      ST_STORE_WRITE: dmem_write = is_store;
      ST_UPDATE_PC: begin
        pc_set     = take_branch;
        pc_advance = !take_branch;
      end
      default: ;
    endcase
  end

  always_comb begin
    imm_sel   = IMM5_ZE;
    src_sel_a = SRC_REG;
    src_sel_b = SRC_REG;
    wb_sel    = WB_ALU;
    alu_op    = ALU_ADD;
    case (opcode)
      TYPE_BASIC: begin
        case (sub5)
          ADD: alu_op = ALU_ADD;
          SUB: alu_op = ALU_SUB;
          AND: alu_op = ALU_AND;
          OR:  alu_op = ALU_OR;
          XOR: alu_op = ALU_XOR;
          SRLI: begin
            alu_op    = ALU_SRL;
            src_sel_b = SRC_IMM;
          end
          SLLI: begin
            alu_op    = ALU_SLL;
            src_sel_b = SRC_IMM;
          end
          ROTRI: begin
            alu_op    = ALU_ROR;
            src_sel_b = SRC_IMM;
          end
          default: alu_op = ALU_ADD;
        endcase
      end
      ADDI: begin
        imm_sel   = IMM15_SE;
        src_sel_b = SRC_IMM;
      end
      ORI: begin
        imm_sel   = IMM15_ZE;
        src_sel_b = SRC_IMM;
        alu_op    = ALU_OR;
      end
      XORI: begin
        imm_sel   = IMM15_ZE;
        src_sel_b = SRC_IMM;
        alu_op    = ALU_XOR;
      end
      LWI: begin
        imm_sel   = IMM15_ZE;
        src_sel_b = SRC_IMM;
        wb_sel    = WB_DMEM;
      end
      SWI: begin
        imm_sel   = IMM15_ZE;
        src_sel_b = SRC_IMM;
      end
      MOVI: begin
        // imm or imm passes the immediate through
        imm_sel   = IMM20_SE;
        src_sel_a = SRC_IMM;
        src_sel_b = SRC_IMM;
        alu_op    = ALU_OR;
      end
      BEQ:     alu_op = ALU_SUB;
      TYPE_LS: wb_sel = (sub8 == LW) ? WB_DMEM : WB_ALU;
      default: ;
    endcase
  end

endmodule

/* logic/core_datapath.sv */
// core datapath: program counter, immediate extension, operand muxing, alu and writeback
`timescale 1ns/1ps

module core_datapath import core_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      start,
  input  logic      pc_set,
  input  logic      pc_advance,
  input  logic      reg_read,
  input  logic      reg_write,
  input  logic      alu_execute,
  input  imm_sel_t  imm_sel,
  input  src_sel_t  src_sel_a,
  input  src_sel_t  src_sel_b,
  input  wb_sel_t   wb_sel,
  input  alu_op_t   alu_op,
  input  reg_addr_t rt,
  input  reg_addr_t ra,
  input  reg_addr_t rb,
  input  word_t     imm_field,
  input  word_t     dmem_rdata,
  output mem_addr_t pc,
  output logic      alu_equal,
  output mem_addr_t dmem_addr,
  output word_t     dmem_wdata
);

  word_t     imm_ext;
  word_t     data_a;
  word_t     data_b;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  word_t     result_q;
  word_t     store_q;
  word_t     write_data;
  reg_addr_t read_b_addr;
  logic      equal;

  always_comb begin
    case (imm_sel)
      IMM5_ZE:  imm_ext = {27'd0, imm_field[14:10]};
      IMM15_SE: imm_ext = {{17{imm_field[14]}}, imm_field[14:0]};
      IMM15_ZE: imm_ext = {17'd0, imm_field[14:0]};
      IMM20_SE: imm_ext = {{12{imm_field[19]}}, imm_field[19:0]};
    endcase
  end

  // port b reads rt for stores and beq
  assign read_b_addr = reg_read ? rt : rb;
  assign alu_a       = (src_sel_a == SRC_IMM) ? imm_ext : data_a;
  assign alu_b       = (src_sel_b == SRC_IMM) ? imm_ext : data_b;
  assign write_data  = (wb_sel == WB_DMEM) ? dmem_rdata : result_q;

  register_file regs0 (
    .clock        (clock),
    .reset        (reset),
    .read_a       (ra),
    .read_b       (read_b_addr),
    .write_addr   (rt),
    .write_data   (write_data),
    .write_enable (reg_write),
    .data_a       (data_a),
    .data_b       (data_b)
  );

  alu alu0 (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .equal  (equal)
  );

  always_ff @(posedge clock) begin
    if (reset || start) begin
      pc        <= '0;
      alu_equal <= 1'b0;
    end else begin
      if (pc_set) begin
        // beq and j offsets agree in the low byte, all the pc can hold
        pc <= pc + imm_field[7:0];
      end else if (pc_advance) begin
        pc <= pc + 8'd1;
      end
      if (alu_execute) begin
        alu_equal <= equal;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alu_execute) begin
      result_q <= alu_result;
    end
    if (reg_read) begin
      store_q <= data_b;
    end
  end

  // effective address is the alu sum
  assign dmem_addr  = result_q[7:0];
  assign dmem_wdata = store_q;

endmodule

/* logic/cpu_top.sv */
// cpu top: core, memories and host program loader wired together
`timescale 1ns/1ps

module cpu_top import core_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      host_req,
  input  host_cmd_t host_cmd,
  input  mem_addr_t host_addr,
  input  word_t     host_wdata,
  output logic      host_ack,
  output word_t     host_rdata,
  output logic      done,
  output count_t    ins_count
);

  logic      start;
  logic      running;
  count_t    program_length;
  logic      imem_we;
  mem_addr_t imem_addr;
  word_t     imem_wdata;
  word_t     imem_rdata;
  logic      host_dmem_we;
  mem_addr_t host_dmem_addr;
  word_t     host_dmem_wdata;
  logic      core_access;
  logic      mem_we;
  mem_addr_t mem_addr;
  word_t     mem_wdata;
  word_t     dmem_rdata;
  mem_addr_t dmem_addr;
  word_t     dmem_wdata;
  mem_addr_t pc;
  logic      alu_equal;
  logic      pc_set;
  logic      pc_advance;
  logic      reg_read;
  logic      reg_write;
  logic      alu_execute;
  logic      dmem_read;
  logic      dmem_write;
  imm_sel_t  imm_sel;
  src_sel_t  src_sel_a;
  src_sel_t  src_sel_b;
  wb_sel_t   wb_sel;
  alu_op_t   alu_op;
  reg_addr_t rt;
  reg_addr_t ra;
  reg_addr_t rb;
  word_t     imm_field;

  // core owns the data port on its own accesses during a run
  assign core_access = running && (dmem_read || dmem_write);
  assign mem_we      = core_access ? dmem_write : host_dmem_we;
  assign mem_addr    = core_access ? dmem_addr : host_dmem_addr;
  assign mem_wdata   = core_access ? dmem_wdata : host_dmem_wdata;

  program_loader loader0 (
    .clock           (clock),
    .reset           (reset),
    .host_req        (host_req),
    .host_cmd        (host_cmd),
    .host_addr       (host_addr),
    .host_wdata      (host_wdata),
    .done            (done),
    .dmem_rdata      (dmem_rdata),
    .host_ack        (host_ack),
    .host_rdata      (host_rdata),
    .start           (start),
    .program_length  (program_length),
    .running         (running),
    .imem_we         (imem_we),
    .imem_addr       (imem_addr),
    .imem_wdata      (imem_wdata),
    .host_dmem_we    (host_dmem_we),
    .host_dmem_addr  (host_dmem_addr),
    .host_dmem_wdata (host_dmem_wdata)
  );

  ir_controller ctrl0 (
    .clock          (clock),
    .reset          (reset),
    .start          (start),
    .program_length (program_length),
    .pc             (pc),
    .imem_rdata     (imem_rdata),
    .alu_equal      (alu_equal),
    .pc_set         (pc_set),
    .pc_advance     (pc_advance),
    .reg_read       (reg_read),
    .reg_write      (reg_write),
    .alu_execute    (alu_execute),
    .dmem_read      (dmem_read),
    .dmem_write     (dmem_write),
    .imm_sel        (imm_sel),
    .src_sel_a      (src_sel_a),
    .src_sel_b      (src_sel_b),
    .wb_sel         (wb_sel),
    .alu_op         (alu_op),
    .rt             (rt),
    .ra             (ra),
    .rb             (rb),
    .imm_field      (imm_field),
    .ins_count      (ins_count),
    .done           (done)
  );

  core_datapath datapath0 (
    .clock       (clock),
    .reset       (reset),
    .start       (start),
    .pc_set      (pc_set),
    .pc_advance  (pc_advance),
    .reg_read    (reg_read),
    .reg_write   (reg_write),
    .alu_execute (alu_execute),
    .imm_sel     (imm_sel),
    .src_sel_a   (src_sel_a),
    .src_sel_b   (src_sel_b),
    .wb_sel      (wb_sel),
    .alu_op      (alu_op),
    .rt          (rt),
    .ra          (ra),
    .rb          (rb),
    .imm_field   (imm_field),
    .dmem_rdata  (dmem_rdata),
    .pc          (pc),
    .alu_equal   (alu_equal),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata)
  );

  instr_memory imem0 (
    .clock      (clock),
    .we         (imem_we),
    .write_addr (imem_addr),
    .write_data (imem_wdata),
    .read_addr  (pc),
    .read_data  (imem_rdata)
  );

  data_memory dmem0 (
    .clock (clock),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (dmem_rdata)
  );

endmodule

/* sim/tb_cpu.sv */
// cpu testbench drives the host port, runs the vector file program and checks the results
`timescale 1ns/1ps

module tb_cpu import core_pkg::*; ();

  logic      clock;
  logic      reset;
  logic      host_req;
  host_cmd_t host_cmd;
  mem_addr_t host_addr;
  word_t     host_wdata;
  logic      host_ack;
  word_t     host_rdata;
  logic      done;
  count_t    ins_count;

  // header at 0x00, program at 0x10, initial pairs at 0x40, expected pairs at 0x60
  word_t vectors [0:255];
  word_t rand_words [0:15];
  int    cycles = 0;
  int    cycle_limit = 0;

  cpu_top dut0 (
    .clock      (clock),
    .reset      (reset),
    .host_req   (host_req),
    .host_cmd   (host_cmd),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ack   (host_ack),
    .host_rdata (host_rdata),
    .done       (done),
    .ins_count  (ins_count)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("run did not finish before the timeout");
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped after %0d cycles", cycles);
    end
  end

  function automatic word_t xorshift(input word_t state);
    word_t s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_equal(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  // one full four-phase request with ack checked low after release
  task automatic host_access(input host_cmd_t cmd, input mem_addr_t addr,
                             input word_t wdata, output word_t rdata);
    @(posedge clock);
    #2;
    host_cmd   = cmd;
    host_addr  = addr;
    host_wdata = wdata;
    host_req   = 1'b1;
    do begin
      @(posedge clock);
      #2;
    end while (!host_ack);
    rdata    = host_rdata;
    host_req = 1'b0;
    @(posedge clock);
    #2;
    check_equal({31'd0, host_ack}, 32'd0, "ack low after release");
  endtask

  task automatic load_initial_data();
    word_t unused;
    int    i;
    for (i = 0; i < int'(vectors[1]); i++) begin
      host_access(CMD_WRITE_DMEM, vectors[8'h40 + 2 * i][7:0], vectors[8'h41 + 2 * i],
                  unused);
    end
  endtask

  // every result word gets a wrong value so the rerun has to store it again
  task automatic scrub_results();
    word_t unused;
    int    i;
    for (i = 0; i < int'(vectors[2]); i++) begin
      host_access(CMD_WRITE_DMEM, vectors[8'h60 + 2 * i][7:0], ~vectors[8'h61 + 2 * i],
                  unused);
    end
  endtask

  task automatic run_and_check(input int pass);
    word_t unused;
    word_t got;
    int    i;
    host_access(CMD_START, 8'd0, vectors[0], unused);
    check_equal({31'd0, done}, 32'd0, "done low after start");
    check_equal({16'd0, ins_count}, 32'd0, "count cleared by start");
    while (!done) begin
      @(posedge clock);
      #2;
    end
    $display("run %0d finished at %0t ns", pass, $time);
    check_equal({16'd0, ins_count}, vectors[3], "retired instruction count");
    for (i = 0; i < int'(vectors[2]); i++) begin
      host_access(CMD_READ_DMEM, vectors[8'h60 + 2 * i][7:0], 32'd0, got);
      check_equal(got, vectors[8'h61 + 2 * i], $sformatf("data word %h",
                  vectors[8'h60 + 2 * i][7:0]));
    end
    check_equal({31'd0, done}, 32'd1, "done held after run");
  endtask

  initial begin
    word_t seed;
    word_t unused;
    word_t got;
    int    requests;
    int    i;
    reset      = 1'b1;
    host_req   = 1'b0;
    host_cmd   = CMD_WRITE_IMEM;
    host_addr  = '0;
    host_wdata = '0;
    $readmemh("sim/cpu_vectors.txt", vectors);
    requests = 32 + int'(vectors[0]) + 2 * int'(vectors[1]) + 3 * int'(vectors[2]) + 2;
    cycle_limit = 9 * 4 * int'(vectors[0]) + 2 * 8 * requests + 16;

    repeat (4) @(posedge clock);
    #2;
    reset = 1'b0;
    check_equal({31'd0, done}, 32'd0, "done low after reset");

    // host port write then read back above the program data
    seed = 32'hf70d8618;
    for (i = 0; i < 16; i++) begin
      seed = xorshift(seed);
      rand_words[i] = seed;
      host_access(CMD_WRITE_DMEM, 8'h80 + i[7:0], seed, unused);
    end
    for (i = 0; i < 16; i++) begin
      host_access(CMD_READ_DMEM, 8'h80 + i[7:0], 32'd0, got);
      check_equal(got, rand_words[i], "host readback");
    end

    for (i = 0; i < int'(vectors[0]); i++) begin
      host_access(CMD_WRITE_IMEM, i[7:0], vectors[8'h10 + i], unused);
    end
    load_initial_data();

    run_and_check(1);
    // second start must clear status and give the same results
    scrub_results();
    load_initial_data();
    run_and_check(2);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* files.f */
logic/core_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/instr_memory.sv
logic/data_memory.sv
logic/program_loader.sv
logic/ir_controller.sv
logic/core_datapath.sv
logic/cpu_top.sv
sim/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
RTL_TOP   ?= cpu_top
VECTORS   ?= sim/cpu_vectors.txt
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

SOURCES := $(wildcard logic/*.sv) $(wildcard sim/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): files.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f files.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP) $(VECTORS)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -f files.f --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/cpu_vectors.txt */
// header: program length, initial pair count, expected pair count, retired count
// program words from 0x10; pairs are address then word, initial at 0x40, expected at 0x60
@00
00000027 00000005 00000011 00000023
@10
441FFFF5 44200123 50317FFD 58414A00 5650F00F 40610C00 40718401 40829002
40931C04 40A31C03 40B29009 40C12008 40D2200B 40000009 04E00020 44F00021
39003C02 14100040 14300041 14400042 14500043 14600044 14700045 14800046
14900047 14A00048 14B00049 14C0004A 14D0004B 14E0004C 4510004D 3900440A
4C218002 14200051 4C948002 14100050 48000002 14100052 40000009
@40
00000020 80000001 00000021 000000F0 00000050 A5A50050 00000051 A5A50051
00000052 A5A50052
@60
00000040 FFFFFFF5 00000041 00000120 00000042 00004B23 00000043 FFFF8FFA
00000044 00000243 00000045 0000012B 00000046 00000B22 00000047 0000036B
00000048 00000368 00000049 0FFFF8FF 0000004A 00012300 0000004B 2300004B
0000004C 80000001 0000004D 000000F0 00000050 A5A50050 00000051 00000123
00000052 A5A50052
